// ==== Makefile ====
TOP = tb_matrix_calc

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== files.f ====
src/matrix_store_pkg.sv
src/matrix_ui_pkg.sv
src/mem_port_if.sv
src/dir_if.sv
src/slot_directory.sv
src/element_ram.sv
src/matrix_entry.sv
src/matrix_dump.sv
src/panel_ctrl.sv
src/matrix_calc_top.sv
verification/matrix_calc_sva.sv
verification/tb_matrix_calc.sv

// ==== src/dir_if.sv ====
// Allocate, commit and query bundle of the slot directory.
// Slot indices are a full byte so that out of range requests can be rejected.
`timescale 1ns/100ps

interface dir_if
    import matrix_store_pkg::*;
(
    input logic clk
);
    // Allocation, answered one cycle after alloc_req
    logic       alloc_req;
    dim_t       alloc_m;
    dim_t       alloc_n;
    logic       alloc_done;
    logic       alloc_ok;
    logic [7:0] alloc_slot;
    ram_addr_t  alloc_addr;

    // Commit of the pending slot
    logic       commit_req;

    // Combinational lookup
    logic [7:0] query_slot;
    logic       query_valid;
    dim_t       query_m;
    dim_t       query_n;
    ram_addr_t  query_addr;

    modport producer (
        input  clk,
        output alloc_req, alloc_m, alloc_n, commit_req,
        input  alloc_done, alloc_ok, alloc_addr
    );

    modport consumer (
        input  clk,
        output query_slot,
        input  query_valid, query_m, query_n, query_addr
    );

    modport directory (
        input  clk, alloc_req, alloc_m, alloc_n, commit_req, query_slot,
        output alloc_done, alloc_ok, alloc_slot, alloc_addr,
        output query_valid, query_m, query_n, query_addr
    );

endinterface

// ==== src/element_ram.sv ====
// Simple dual-port element memory, one write and one registered read port.
// A read of the address being written returns the old value.
`timescale 1ns/100ps

module element_ram
    import matrix_store_pkg::*;
(
    input  logic    clk,
    mem_port_if.ram mem
);
    elem_t mem_array [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            mem_array[mem.waddr] <= mem.wdata;
        end
        // rdata holds between reads
        if (mem.re) begin
            mem.rdata <= mem_array[mem.raddr];
        end
    end

endmodule

// ==== src/matrix_calc_top.sv ====
// Matrix store and dump top level with byte strobes in and out.
// tx_busy must be a level from the byte sink, tx_valid never rises while it is high.
`timescale 1ns/100ps

module matrix_calc_top
    import matrix_ui_pkg::*;
#(
    parameter int SLOTS    = 8,
    parameter int ERR_HOLD = 50_000_000,
    parameter int SCAN_DIV = 2_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       btn_confirm,
    input  logic       btn_back,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       tx_busy,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic       err_led,
    output logic [1:0] led_status,
    output logic [6:0] seg_display,
    output logic [1:0] seg_select
);
    logic entry_active;
    logic dump_active;
    err_t entry_err;
    err_t dump_err;

    mem_port_if mem_bus (.clk(clk));
    dir_if      dir_bus (.clk(clk));

    panel_ctrl #(
        .ERR_HOLD (ERR_HOLD),
        .SCAN_DIV (SCAN_DIV)
    ) u_panel (
        .clk          (clk),
        .rst_n        (rst_n),
        .dip_sw       (dip_sw),
        .btn_confirm  (btn_confirm),
        .btn_back     (btn_back),
        .entry_err    (entry_err),
        .dump_err     (dump_err),
        .entry_active (entry_active),
        .dump_active  (dump_active),
        .err_led      (err_led),
        .led_status   (led_status),
        .seg_display  (seg_display),
        .seg_select   (seg_select)
    );

    matrix_entry u_entry (
        .clk      (clk),
        .rst_n    (rst_n),
        .active   (entry_active),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .err      (entry_err),
        .dir      (dir_bus.producer),
        .mem      (mem_bus.writer)
    );

    matrix_dump u_dump (
        .clk      (clk),
        .rst_n    (rst_n),
        .active   (dump_active),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .err      (dump_err),
        .dir      (dir_bus.consumer),
        .mem      (mem_bus.reader)
    );

    slot_directory #(
        .SLOTS (SLOTS)
    ) u_dir (
        .clk   (clk),
        .rst_n (rst_n),
        .dir   (dir_bus.directory)
    );

    element_ram u_ram (
        .clk (clk),
        .mem (mem_bus.ram)
    );

endmodule

// ==== src/matrix_dump.sv ====
// Dump mode. A received byte names a slot, its header and elements go out
// in address order. Bytes received while a dump is running are ignored.
`timescale 1ns/100ps

module matrix_dump
    import matrix_store_pkg::*, matrix_ui_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        active,
    input  elem_t       rx_data,
    input  logic        rx_valid,
    input  logic        tx_busy,
    output elem_t       tx_data,
    output logic        tx_valid,
    output err_t        err,
    dir_if.consumer     dir,
    mem_port_if.reader  mem
);
    typedef enum logic [1:0] {
        D_IDLE,
        D_CHECK,
        D_RUN
    } dump_state_t;

    dump_state_t state;
    elem_t       slot_q;
    elem_t       out_buf;
    logic        out_full;
    logic        rd_pending;
    logic [7:0]  remaining;
    ram_addr_t   rd_ptr;
    logic        send;
    logic        move;

    assign dir.query_slot = slot_q;
    assign tx_data        = out_buf;

    // ========================================
    // Output buffer and read issue
    // ========================================
    assign send     = active && (state == D_RUN) && out_full && !tx_busy;
    assign tx_valid = send;

    // rd_pending means rdata holds an element not yet in the buffer
    assign move      = rd_pending && (!out_full || send);
    assign mem.re    = active && (state == D_RUN) && (remaining != '0) &&
                       (!rd_pending || move);
    assign mem.raddr = rd_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= D_IDLE;
            out_full   <= 1'b0;
            rd_pending <= 1'b0;
            remaining  <= '0;
            rd_ptr     <= '0;
            err        <= ERR_NONE;
        end else begin
            err        <= ERR_NONE;
            rd_pending <= mem.re || (rd_pending && !move);
            if (!active) begin
                state     <= D_IDLE;
                out_full  <= 1'b0;
                remaining <= '0;
            end else begin
                case (state)
                    D_IDLE: begin
                        if (rx_valid) begin
                            state <= D_CHECK;
                        end
                    end
                    D_CHECK: begin
                        if (dir.query_valid) begin
                            out_full  <= 1'b1;
                            remaining <= dir.query_m * dir.query_n;
                            rd_ptr    <= dir.query_addr;
                            state     <= D_RUN;
                        end else begin
                            err   <= ERR_SLOT;
                            state <= D_IDLE;
                        end
                    end
                    D_RUN: begin
                        if (mem.re) begin
                            rd_ptr    <= rd_ptr + 8'd1;
                            remaining <= remaining - 8'd1;
                        end
                        if (move) begin
                            out_full <= 1'b1;
                        end else if (send) begin
                            out_full <= 1'b0;
                        end
                        if (remaining == '0 && !rd_pending && !out_full) begin
                            state <= D_IDLE;
                        end
                    end
                    default: state <= D_IDLE;
                endcase
            end
        end
    end

    // Header byte first, then elements as they come back from the RAM
    always_ff @(posedge clk) begin
        if (state == D_IDLE && rx_valid) begin
            slot_q <= rx_data;
        end
        if (state == D_CHECK) begin
            out_buf <= {dir.query_m, dir.query_n};
        end else if (move) begin
            out_buf <= mem.rdata;
        end
    end

endmodule

// ==== src/matrix_entry.sv ====
// Entry mode. A header byte (rows high nibble, cols low) is followed by
// rows*cols element bytes. Element bytes must start at least three cycles
// after the header, earlier ones are dropped while allocation is pending.
`timescale 1ns/100ps

module matrix_entry
    import matrix_store_pkg::*, matrix_ui_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        active,
    input  entry_byte_u rx_data,
    input  logic        rx_valid,
    output err_t        err,
    dir_if.producer     dir,
    mem_port_if.writer  mem
);
    typedef enum logic [1:0] {
        E_HDR,
        E_WAIT,
        E_ELEM,
        E_COMMIT
    } entry_state_t;

    entry_state_t state;
    logic [7:0]   remaining;
    ram_addr_t    wr_ptr;
    logic         we_q;
    logic         hdr_ok;

    // Header view of the received byte
    assign hdr_ok = (rx_data.hdr.rows != '0) && (rx_data.hdr.cols != '0) &&
                    (rx_data.hdr.rows <= dim_t'(MAX_DIM)) &&
                    (rx_data.hdr.cols <= dim_t'(MAX_DIM));

    // A pending write dies as soon as the panel leaves entry mode
    assign mem.we = we_q && active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= E_HDR;
            remaining      <= '0;
            wr_ptr         <= '0;
            we_q           <= 1'b0;
            dir.alloc_req  <= 1'b0;
            dir.commit_req <= 1'b0;
            err            <= ERR_NONE;
        end else begin
            we_q           <= 1'b0;
            dir.alloc_req  <= 1'b0;
            dir.commit_req <= 1'b0;
            err            <= ERR_NONE;
            if (!active) begin
                state <= E_HDR;
            end else begin
                case (state)
                    E_HDR: begin
                        if (rx_valid && hdr_ok) begin
                            dir.alloc_req <= 1'b1;
                            state         <= E_WAIT;
                        end else if (rx_valid) begin
                            err <= ERR_DIM;
                        end
                    end
                    E_WAIT: begin
                        if (dir.alloc_done && dir.alloc_ok) begin
                            remaining <= dir.alloc_m * dir.alloc_n;
                            wr_ptr    <= dir.alloc_addr;
                            state     <= E_ELEM;
                        end else if (dir.alloc_done) begin
                            err   <= ERR_FULL;
                            state <= E_HDR;
                        end
                    end
                    E_ELEM: begin
                        if (rx_valid) begin
                            we_q      <= 1'b1;
                            wr_ptr    <= wr_ptr + 8'd1;
                            remaining <= remaining - 8'd1;
                            if (remaining == 8'd1) begin
                                state <= E_COMMIT;
                            end
                        end
                    end
                    // Last write is on the bus now, commit follows it
                    E_COMMIT: begin
                        dir.commit_req <= 1'b1;
                        state          <= E_HDR;
                    end
                    default: state <= E_HDR;
                endcase
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == E_HDR && rx_valid) begin
            dir.alloc_m <= rx_data.hdr.rows;
            dir.alloc_n <= rx_data.hdr.cols;
        end
        if (state == E_ELEM && rx_valid) begin
            mem.waddr <= wr_ptr;
            mem.wdata <= rx_data.elem;
        end
    end

endmodule

// ==== src/matrix_store_pkg.sv ====
// Storage types for the element RAM and the slot directory.
// Dimensions are limited to MAX_DIM, so rows*cols always fits in one byte.
package matrix_store_pkg;

    typedef logic [7:0] elem_t;
    typedef logic [7:0] ram_addr_t;
    typedef logic [3:0] dim_t;

    localparam int MAX_DIM   = 5;
    localparam int RAM_DEPTH = 256;

    // Header byte with rows in the upper nibble
    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } entry_hdr_t;

    // One received byte in entry mode
    typedef union packed {
        entry_hdr_t hdr;
        elem_t      elem;
    } entry_byte_u;

endpackage

// ==== src/matrix_ui_pkg.sv ====
// Panel mode and error encodings, plus seven-segment patterns.
// Segment patterns are active high in gfedcba order.
package matrix_ui_pkg;

    typedef enum logic [1:0] {
        MODE_MENU  = 2'd0,
        MODE_ENTRY = 2'd1,
        MODE_DUMP  = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        ERR_NONE = 2'd0,
        ERR_DIM  = 2'd1,
        ERR_FULL = 2'd2,
        ERR_SLOT = 2'd3
    } err_t;

    // Digits 0 to 9
    localparam logic [6:0] SEG_DIGIT [10] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66,
        7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f
    };

endpackage

// ==== src/mem_port_if.sv ====
// Write and read port bundle of the element RAM.
// rdata is valid one cycle after re and holds until the next read.
`timescale 1ns/100ps

interface mem_port_if
    import matrix_store_pkg::*;
(
    input logic clk
);
    logic      we;
    ram_addr_t waddr;
    elem_t     wdata;
    logic      re;
    ram_addr_t raddr;
    elem_t     rdata;

    modport writer (input clk, output we, waddr, wdata);
    modport reader (input clk, output re, raddr, input rdata);
    modport ram    (input clk, input we, waddr, wdata, re, raddr, output rdata);

endinterface

// ==== src/panel_ctrl.sv ====
// Menu FSM, error LED timer and two-digit display scan.
// Buttons are taken as clean single-cycle pulses, no debounce here.
`timescale 1ns/100ps

module panel_ctrl
    import matrix_ui_pkg::*;
#(
    parameter int ERR_HOLD = 50_000_000,
    parameter int SCAN_DIV = 2_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       btn_confirm,
    input  logic       btn_back,
    input  err_t       entry_err,
    input  err_t       dump_err,
    output logic       entry_active,
    output logic       dump_active,
    output logic       err_led,
    output err_t       led_status,
    output logic [6:0] seg_display,
    output logic [1:0] seg_select
);
    localparam int HOLD_W = $clog2(ERR_HOLD + 1);
    localparam int SCAN_W = $clog2(SCAN_DIV + 1);

    mode_t             mode;
    mode_t             mode_next;
    err_t              err_in;
    err_t              last_err;
    logic [HOLD_W-1:0] hold_cnt;
    logic [SCAN_W-1:0] scan_cnt;
    logic [3:0]        digit;

    // ========================================
    // Menu FSM
    // ========================================
    always_comb begin
        mode_next = mode;
        if (mode == MODE_MENU) begin
            if (btn_confirm && dip_sw == 3'd1) begin
                mode_next = MODE_ENTRY;
            end else if (btn_confirm && dip_sw == 3'd2) begin
                mode_next = MODE_DUMP;
            end
        end else if (btn_back) begin
            mode_next = MODE_MENU;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    assign entry_active = (mode == MODE_ENTRY);
    assign dump_active  = (mode == MODE_DUMP);

    // Only the active mode can raise an error
    assign err_in = (entry_err != ERR_NONE) ? entry_err : dump_err;

    // ========================================
    // Error LED hold
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_led    <= 1'b0;
            led_status <= ERR_NONE;
            last_err   <= ERR_NONE;
            hold_cnt   <= '0;
        end else if (err_in != ERR_NONE) begin
            err_led    <= 1'b1;
            led_status <= err_in;
            last_err   <= err_in;
            hold_cnt   <= HOLD_W'(ERR_HOLD - 1);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end else begin
            err_led    <= 1'b0;
            led_status <= ERR_NONE;
        end
    end

    // ========================================
    // Display scan
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt   <= '0;
            seg_select <= 2'b01;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt   <= '0;
            seg_select <= ~seg_select;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Digit 01 shows the mode, digit 10 the last error
    assign digit       = seg_select[0] ? 4'(mode) : 4'(last_err);
    assign seg_display = SEG_DIGIT[digit];

endmodule

// ==== src/slot_directory.sv ====
// Table of stored matrices. SLOTS must lie between 2 and 255.
// Space is handed out by a bump pointer and never freed.
`timescale 1ns/100ps

module slot_directory
    import matrix_store_pkg::*;
#(
    parameter int SLOTS = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    dir_if.directory    dir
);
    localparam int         SW          = $clog2(SLOTS);
    localparam logic [7:0] SLOT_LIMIT  = 8'(SLOTS);
    localparam logic [8:0] DEPTH_LIMIT = 9'(RAM_DEPTH);

    logic [SLOTS-1:0] valid;
    dim_t             slot_m    [SLOTS];
    dim_t             slot_n    [SLOTS];
    ram_addr_t        slot_base [SLOTS];
    logic [7:0]       next_slot;
    logic [8:0]       bump;
    logic [7:0]       need;
    logic             fits;

    assign need = dir.alloc_m * dir.alloc_n;
    assign fits = (next_slot < SLOT_LIMIT) && ((bump + 9'(need)) <= DEPTH_LIMIT);

    // ========================================
    // Allocation and commit
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid          <= '0;
            next_slot      <= '0;
            bump           <= '0;
            dir.alloc_done <= 1'b0;
            dir.alloc_ok   <= 1'b0;
            dir.alloc_slot <= '0;
            dir.alloc_addr <= '0;
        end else begin
            dir.alloc_done <= dir.alloc_req;
            dir.alloc_ok   <= dir.alloc_req && fits;
            if (dir.alloc_req && fits) begin
                dir.alloc_slot <= next_slot;
                dir.alloc_addr <= bump[7:0];
                next_slot      <= next_slot + 8'd1;
                bump           <= bump + 9'(need);
            end
            // alloc_slot still names the pending slot here
            if (dir.commit_req) begin
                valid[dir.alloc_slot[SW-1:0]] <= 1'b1;
            end
        end
    end

    // Entry contents are written at allocation, valid only rises on commit
    always_ff @(posedge clk) begin
        if (dir.alloc_req && fits) begin
            slot_m[next_slot[SW-1:0]]    <= dir.alloc_m;
            slot_n[next_slot[SW-1:0]]    <= dir.alloc_n;
            slot_base[next_slot[SW-1:0]] <= bump[7:0];
        end
    end

    // ========================================
    // Query
    // ========================================
    always_comb begin
        dir.query_valid = (dir.query_slot < SLOT_LIMIT) && valid[dir.query_slot[SW-1:0]];
        dir.query_m     = slot_m[dir.query_slot[SW-1:0]];
        dir.query_n     = slot_n[dir.query_slot[SW-1:0]];
        dir.query_addr  = slot_base[dir.query_slot[SW-1:0]];
    end

endmodule

// ==== verification/matrix_calc_sva.sv ====
// Bound protocol checks on the matrix calculator top level.
// A new error inside a running hold window counts as one long lit period.
`timescale 1ns/100ps

module matrix_calc_sva
    import matrix_ui_pkg::*;
#(
    parameter int ERR_HOLD = 64
) (
    input logic       clk,
    input logic       rst_n,
    input logic [2:0] dip_sw,
    input logic       btn_confirm,
    input logic       btn_back,
    input logic       tx_valid,
    input logic       tx_busy,
    input logic       err_led,
    input logic       ram_we
);
    int    lit_cycles;
    mode_t mode_ref;

    // Consecutive cycles with the error LED lit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lit_cycles <= 0;
        end else if (err_led) begin
            lit_cycles <= lit_cycles + 1;
        end else begin
            lit_cycles <= 0;
        end
    end

    // Mode expected from the buttons and switches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_ref <= MODE_MENU;
        end else if (mode_ref == MODE_MENU && btn_confirm) begin
            if (dip_sw == 3'd1) begin
                mode_ref <= MODE_ENTRY;
            end else if (dip_sw == 3'd2) begin
                mode_ref <= MODE_DUMP;
            end
        end else if (mode_ref != MODE_MENU && btn_back) begin
            mode_ref <= MODE_MENU;
        end
    end

    tx_held_off: assert property (@(posedge clk) disable iff (!rst_n) tx_valid |-> !tx_busy)
        else $error("tx_valid high while tx_busy is high");

    err_led_clears: assert property (@(posedge clk) disable iff (!rst_n)
        err_led |-> (lit_cycles <= ERR_HOLD + 2))
        else $error("err_led lit longer than ERR_HOLD + 2 cycles");

    write_in_entry: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> (mode_ref == MODE_ENTRY))
        else $error("element RAM written outside entry mode");

endmodule

bind matrix_calc_top matrix_calc_sva #(
    .ERR_HOLD (ERR_HOLD)
) u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .dip_sw      (dip_sw),
    .btn_confirm (btn_confirm),
    .btn_back    (btn_back),
    .tx_valid    (tx_valid),
    .tx_busy     (tx_busy),
    .err_led     (err_led),
    .ram_we      (mem_bus.we)
);

// ==== verification/tb_matrix_calc.sv ====
// Random store and dump testbench for the matrix calculator top level.
// Error cases run one at a time, each waits for the error LED to go dark.
// Bytes on tx are sampled in the low clock phase, after tx_busy has settled.
`timescale 1ns/100ps

module tb_matrix_calc
    import matrix_store_pkg::*, matrix_ui_pkg::*;
();
    localparam int SLOTS      = 8;
    localparam int ERR_HOLD   = 64;
    localparam int SCAN_DIV   = 8;
    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 32'h2a16_865a;
    localparam int MAX_BYTES  = 3 * SLOTS * (1 + MAX_DIM * MAX_DIM);
    localparam int ERR_CASES  = 8;
    localparam int WATCHDOG_CYCLES = MAX_BYTES * 16 + ERR_CASES * (ERR_HOLD + 16) +
                                     16 * SCAN_DIV + 500;

    logic       clk;
    logic       rst_n;
    logic [2:0] dip_sw;
    logic       btn_confirm;
    logic       btn_back;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       tx_busy;
    logic       busy_enable;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       err_led;
    logic [1:0] led_status;
    logic [6:0] seg_display;
    logic [1:0] seg_select;

    // Model of the directory and the element RAM
    int         model_m    [$];
    int         model_n    [$];
    int         model_base [$];
    bit         model_done [$];
    logic [7:0] model_mem  [RAM_DEPTH];
    int         model_used;
    logic [7:0] tx_seen    [$];

    matrix_calc_top #(
        .SLOTS    (SLOTS),
        .ERR_HOLD (ERR_HOLD),
        .SCAN_DIV (SCAN_DIV)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .dip_sw      (dip_sw),
        .btn_confirm (btn_confirm),
        .btn_back    (btn_back),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .tx_busy     (tx_busy),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .err_led     (err_led),
        .led_status  (led_status),
        .seg_display (seg_display),
        .seg_select  (seg_select)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Helpers
    // ========================================
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic select_mode(input logic [2:0] sel);
        dip_sw      = sel;
        btn_confirm = 1'b1;
        @(negedge clk);
        btn_confirm = 1'b0;
        @(negedge clk);
    endtask

    task automatic leave_mode();
        btn_back = 1'b1;
        @(negedge clk);
        btn_back = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] value);
        rx_data  = value;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        rx_data  = 8'h00;
    endtask

    // Standard gfedcba digit patterns
    function automatic logic [6:0] seg_pattern(input int digit);
        case (digit)
            0:       return 7'h3f;
            1:       return 7'h06;
            2:       return 7'h5b;
            default: return 7'h4f;
        endcase
    endfunction

    function automatic bit alloc_fits(input int m, input int n);
        return (model_m.size() < SLOTS) && (model_used + m * n <= RAM_DEPTH);
    endfunction

    task automatic expect_error(input err_t code);
        int waited;
        waited = 0;
        while (!err_led && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        assert (err_led) else fail_now("error LED did not light after a bad request");
        assert (led_status == code)
            else fail_now($sformatf("mismatch led_status: expected %h, got %h", code, led_status));
        waited = 0;
        while (err_led && waited < ERR_HOLD + 2) begin
            @(negedge clk);
            waited++;
        end
        assert (!err_led) else fail_now("error LED stayed lit past its hold time");
        assert (led_status == 2'h0)
            else fail_now($sformatf("mismatch led_status: expected 0, got %h", led_status));
    endtask

    // Header, then count elements; count below m*n leaves the entry open
    task automatic enter_matrix(input int m, input int n, input int count);
        logic [7:0] value;
        int         base;
        base = model_used;
        send_byte({4'(m), 4'(n)});
        // Allocation answer takes three cycles after the header
        idle(2 + $urandom_range(0, 2));
        for (int i = 0; i < count; i++) begin
            value = 8'($urandom);
            model_mem[base + i] = value;
            send_byte(value);
            idle($urandom_range(0, 2));
        end
        model_m.push_back(m);
        model_n.push_back(n);
        model_base.push_back(base);
        model_done.push_back(count == m * n);
        model_used += m * n;
        idle(4);
        assert (!err_led) else fail_now("error LED lit during a legal matrix entry");
    endtask

    task automatic dump_matrix(input int slot);
        int         expected;
        int         waited;
        logic [7:0] want;
        expected = 1 + model_m[slot] * model_n[slot];
        tx_seen.delete();
        send_byte(8'(slot));
        waited = 0;
        while (tx_seen.size() < expected && waited < expected * 16 + 16) begin
            @(negedge clk);
            waited++;
        end
        idle(4);
        assert (tx_seen.size() == expected)
            else fail_now($sformatf("dump of slot %0d sent %0d bytes instead of %0d",
                                    slot, tx_seen.size(), expected));
        want = {4'(model_m[slot]), 4'(model_n[slot])};
        assert (tx_seen[0] == want)
            else fail_now($sformatf("mismatch tx_data header of slot %0d: expected %h, got %h",
                                    slot, want, tx_seen[0]));
        for (int i = 1; i < expected; i++) begin
            want = model_mem[model_base[slot] + i - 1];
            assert (tx_seen[i] == want)
                else fail_now($sformatf("mismatch tx_data slot %0d byte %0d: expected %h, got %h",
                                        slot, i, want, tx_seen[i]));
        end
    endtask

    task automatic request_empty_slot(input int slot);
        tx_seen.delete();
        send_byte(8'(slot));
        expect_error(ERR_SLOT);
        assert (tx_seen.size() == 0) else fail_now("bytes were sent for an empty slot");
    endtask

    task automatic check_display(input int mode_num);
        int waited;
        waited = 0;
        while (seg_select != 2'b01 && waited < 2 * SCAN_DIV + 2) begin
            @(negedge clk);
            waited++;
        end
        assert (seg_select == 2'b01) else fail_now("display scan never reached the mode digit");
        assert (seg_display == seg_pattern(mode_num))
            else fail_now($sformatf("mismatch seg_display: expected %h, got %h",
                                    seg_pattern(mode_num), seg_display));
    endtask

    // ========================================
    // Background processes
    // ========================================
    always @(negedge clk) begin
        tx_busy = busy_enable && ($urandom_range(0, 3) == 0);
    end

    // Low phase sample, the byte is taken at the next rising edge
    always begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        if (rst_n && tx_valid) begin
            assert (!tx_busy) else fail_now("tx_valid was high while tx_busy was high");
            tx_seen.push_back(tx_data);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_now($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int m;
        int n;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        dip_sw      = 3'd0;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        tx_busy     = 1'b0;
        busy_enable = 1'b0;
        model_used  = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        assert (tx_valid == 1'b0)
            else fail_now($sformatf("mismatch tx_valid: expected 0, got %h", tx_valid));
        assert (err_led == 1'b0)
            else fail_now($sformatf("mismatch err_led: expected 0, got %h", err_led));
        assert (led_status == 2'h0)
            else fail_now($sformatf("mismatch led_status: expected 0, got %h", led_status));
        assert (seg_select == 2'b01)
            else fail_now($sformatf("mismatch seg_select: expected 1, got %h", seg_select));
        check_display(int'(MODE_MENU));
        busy_enable = 1'b1;

        // Bad headers take no slot
        select_mode(3'd1);
        check_display(int'(MODE_ENTRY));
        send_byte(8'h03);
        expect_error(ERR_DIM);
        send_byte(8'h40);
        expect_error(ERR_DIM);
        send_byte({4'(MAX_DIM + 1), 4'd2});
        expect_error(ERR_DIM);
        send_byte({4'd1, 4'(MAX_DIM + 1)});
        expect_error(ERR_DIM);

        for (int k = 0; k < 5; k++) begin
            m = $urandom_range(1, MAX_DIM);
            n = $urandom_range(1, MAX_DIM);
            enter_matrix(m, n, m * n);
        end
        // Abort halfway, the slot stays consumed
        enter_matrix(2, 3, 1);
        leave_mode();

        select_mode(3'd2);
        check_display(int'(MODE_DUMP));
        for (int k = 0; k < 5; k++) begin
            dump_matrix(k);
        end
        request_empty_slot(5);
        request_empty_slot(SLOTS + 3);
        leave_mode();

        // Fill the directory, the next header is refused
        select_mode(3'd1);
        m = $urandom_range(1, MAX_DIM);
        n = $urandom_range(1, MAX_DIM);
        while (alloc_fits(m, n)) begin
            enter_matrix(m, n, m * n);
            m = $urandom_range(1, MAX_DIM);
            n = $urandom_range(1, MAX_DIM);
        end
        send_byte({4'(m), 4'(n)});
        expect_error(ERR_FULL);
        leave_mode();

        select_mode(3'd2);
        for (int k = 0; k < model_m.size(); k++) begin
            if (model_done[k]) begin
                dump_matrix(k);
            end
        end
        leave_mode();
        check_display(int'(MODE_MENU));

        $display("All tests passed");
        $finish;
    end

endmodule
